//--- src/opl_pkg.sv
// FM operator scheduler definitions
package opl_pkg;

    localparam int NUM_BANKS        = 2;
    localparam int NUM_OPS_PER_BANK = 18;
    localparam int NUM_CH_PER_BANK  = 9;
    localparam int NUM_SLOTS        = NUM_BANKS * NUM_OPS_PER_BANK;
    localparam int SLOT_CYCLES      = 7;
    localparam int FETCH_CYCLES     = 4;  // operator starts right after the fetches

    typedef logic [5:0]         slot_t;      // bank * 18 + operator
    typedef logic [4:0]         chan_t;      // bank * 9 + channel
    typedef logic [9:0]         fnum_t;
    typedef logic [2:0]         block_t;
    typedef logic [2:0]         fb_t;
    typedef logic [5:0]         tl_t;
    typedef logic signed [12:0] op_out_t;
    typedef logic [5:0]         conn_sel_t;  // bank * 3 + column
    typedef logic [17:0]        ram_word_t;
    typedef logic [6:0]         ram_addr_t;
    typedef logic [31:0]        wb_data_t;

    localparam ram_addr_t CH_BASE   = 7'd0;
    localparam ram_addr_t TL_BASE   = 7'd32;
    localparam ram_addr_t CONN_ADDR = 7'd127;

    // channel word: kon, cnt, fb, block, fnum
    localparam int FNUM_LSB  = 0;
    localparam int BLOCK_LSB = 10;
    localparam int FB_LSB    = 13;
    localparam int CNT_BIT   = 16;
    localparam int KON_BIT   = 17;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    function automatic logic slot_bank(slot_t slot);
        return slot >= slot_t'(NUM_OPS_PER_BANK);
    endfunction

    function automatic logic [4:0] slot_op(slot_t slot);
        return slot_bank(slot) ? 5'(slot - slot_t'(NUM_OPS_PER_BANK)) : slot[4:0];
    endfunction

endpackage

//--- src/param_ram.sv
// Parameter register RAM
`timescale 1ns/1ps

module param_ram (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               ram_we,
    input  opl_pkg::ram_addr_t ram_adr,
    input  opl_pkg::ram_word_t ram_wdat,
    output opl_pkg::ram_word_t ram_rdat
);
    // channel words, total levels and connection select share one space
    opl_pkg::ram_word_t mem [2**$bits(opl_pkg::ram_addr_t)];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**$bits(opl_pkg::ram_addr_t); i++) begin
                mem[i] <= '0;
            end
            ram_rdat <= '0;
        end else begin
            if (ram_we) begin
                mem[ram_adr] <= ram_wdat;
            end
            ram_rdat <= mem[ram_adr];  // old data on a write
        end
    end

endmodule

//--- src/reg_arbiter.sv
// Register RAM port arbiter
`timescale 1ns/1ps

module reg_arbiter (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  opl_pkg::ram_addr_t wb_adr,
    input  opl_pkg::wb_data_t  wb_dat_w,
    output opl_pkg::wb_data_t  wb_dat_r,
    output logic               wb_ack,
    input  logic               fetch_req,
    input  opl_pkg::ram_addr_t fetch_adr,
    output opl_pkg::ram_word_t fetch_dat,
    output logic               ram_we,
    output opl_pkg::ram_addr_t ram_adr,
    output opl_pkg::ram_word_t ram_wdat,
    input  opl_pkg::ram_word_t ram_rdat
);
    logic host_req;
    logic host_gnt;
    logic host_gnt_q;  // granted last cycle, data now on ram_rdat

    // host still holds stb during its ack cycle, so don't grant it twice
    assign host_req = wb_cyc && wb_stb && !host_gnt_q;
    assign host_gnt = host_req && !fetch_req;  // fetch always wins

    assign ram_adr  = fetch_req ? fetch_adr : wb_adr;
    assign ram_we   = host_gnt && wb_we;
    assign ram_wdat = wb_dat_w[$bits(opl_pkg::ram_word_t)-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            host_gnt_q <= 1'b0;
        end else begin
            host_gnt_q <= host_gnt;
        end
    end

    assign wb_ack    = host_gnt_q;
    assign wb_dat_r  = opl_pkg::wb_data_t'(ram_rdat);  // zero-extended
    assign fetch_dat = ram_rdat;

endmodule

//--- src/slot_sequencer.sv
// Operator slot sequencer
`timescale 1ns/1ps

module slot_sequencer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               sample_en,
    output logic               fetch_req,
    output opl_pkg::ram_addr_t fetch_adr,
    input  opl_pkg::ram_word_t fetch_dat,
    input  opl_pkg::ram_addr_t owner_adr,
    output opl_pkg::slot_t     slot,
    output opl_pkg::conn_sel_t conn_sel,
    output opl_pkg::ram_word_t owner_word,
    output opl_pkg::ram_word_t partner_word,
    output opl_pkg::tl_t       tl,
    output logic               op_start,
    input  opl_pkg::op_out_t   op_out,
    output logic               out_valid,
    output opl_pkg::slot_t     out_slot,
    output opl_pkg::op_out_t   out_value
);
    opl_pkg::seq_state_t                     state;
    logic [$clog2(opl_pkg::SLOT_CYCLES)-1:0] cyc;  // cycle within the slot
    logic                                    last_cyc;
    logic                                    running;
    opl_pkg::conn_sel_t                      conn_q;
    logic [1:0]                              col;
    opl_pkg::ram_addr_t                      partner_adr;
    opl_pkg::ram_addr_t                      tl_adr;

    assign running  = (state == opl_pkg::SEQ_RUN);
    assign last_cyc = (cyc == opl_pkg::SLOT_CYCLES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= opl_pkg::SEQ_IDLE;
            cyc   <= '0;
            slot  <= '0;
        end else begin
            case (state)
                opl_pkg::SEQ_IDLE: begin
                    if (sample_en) begin
                        state <= opl_pkg::SEQ_RUN;  // slot 0 starts next cycle
                    end
                end
                opl_pkg::SEQ_RUN: begin
                    if (last_cyc) begin
                        cyc <= '0;
                        if (slot == opl_pkg::NUM_SLOTS - 1) begin
                            state <= opl_pkg::SEQ_IDLE;
                            slot  <= '0;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
                default: state <= opl_pkg::SEQ_IDLE;
            endcase
        end
    end

    // partner channel sits three columns up in the same bank
    assign col         = 2'(opl_pkg::slot_op(slot) % 3);
    assign partner_adr = opl_pkg::CH_BASE + opl_pkg::ram_addr_t'(
                         opl_pkg::slot_bank(slot) * opl_pkg::NUM_CH_PER_BANK + col + 3);
    assign tl_adr      = opl_pkg::TL_BASE + opl_pkg::ram_addr_t'(slot);

    assign fetch_req = running && (cyc < opl_pkg::FETCH_CYCLES);

    always_comb begin
        case (cyc)
            3'd0:    fetch_adr = opl_pkg::CONN_ADDR;
            3'd1:    fetch_adr = owner_adr;  // router already sees the fresh select
            3'd2:    fetch_adr = partner_adr;
            default: fetch_adr = tl_adr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (running) begin
            case (cyc)
                3'd1:    conn_q       <= fetch_dat[$bits(opl_pkg::conn_sel_t)-1:0];
                3'd2:    owner_word   <= fetch_dat;
                3'd3:    partner_word <= fetch_dat;
                default: ;
            endcase
        end
    end

    assign conn_sel = (cyc == 3'd1) ? fetch_dat[$bits(opl_pkg::conn_sel_t)-1:0] : conn_q;
    assign tl       = fetch_dat[$bits(opl_pkg::tl_t)-1:0];  // level arrives in the start cycle

    assign op_start  = running && (cyc == opl_pkg::FETCH_CYCLES);
    assign out_valid = running && last_cyc;
    assign out_slot  = slot;
    assign out_value = op_out;

endmodule

//--- src/slot_router.sv
// Slot to channel and modulation router
`timescale 1ns/1ps

module slot_router (
    input  opl_pkg::slot_t     slot,
    input  opl_pkg::conn_sel_t conn_sel,
    input  opl_pkg::ram_word_t owner_word,
    input  opl_pkg::ram_word_t partner_word,
    output opl_pkg::ram_addr_t owner_adr,
    output opl_pkg::fnum_t     fnum,
    output opl_pkg::block_t    block,
    output logic               kon,
    output opl_pkg::fb_t       fb,
    output logic               use_feedback,
    output logic               mod_en,
    output opl_pkg::slot_t     mod_slot
);
    logic           bank;
    logic [4:0]     op;       // operator within the bank
    logic [1:0]     col;
    logic [2:0]     row;
    logic           four_op;  // row 2 or 3 joined to the column channel
    logic           cnt_own;
    logic           cnt_partner;
    opl_pkg::chan_t chan;

    always_comb begin
        bank    = opl_pkg::slot_bank(slot);
        op      = opl_pkg::slot_op(slot);
        col     = 2'(op % 3);
        row     = 3'(op / 3);
        four_op = (row == 3'd2 || row == 3'd3) && conn_sel[3 * bank + col];

        if (four_op) begin
            chan = opl_pkg::chan_t'(bank * opl_pkg::NUM_CH_PER_BANK + col);
        end else begin
            chan = opl_pkg::chan_t'(bank * opl_pkg::NUM_CH_PER_BANK + 3 * (row / 2) + col);
        end
        owner_adr = opl_pkg::CH_BASE + opl_pkg::ram_addr_t'(chan);
    end

    assign fnum        = owner_word[opl_pkg::FNUM_LSB +: $bits(opl_pkg::fnum_t)];
    assign block       = owner_word[opl_pkg::BLOCK_LSB +: $bits(opl_pkg::block_t)];
    assign fb          = owner_word[opl_pkg::FB_LSB +: $bits(opl_pkg::fb_t)];
    assign kon         = owner_word[opl_pkg::KON_BIT];
    assign cnt_own     = owner_word[opl_pkg::CNT_BIT];
    assign cnt_partner = partner_word[opl_pkg::CNT_BIT];

    always_comb begin
        if (four_op) begin
            use_feedback = 1'b0;
            if (row == 3'd2) begin
                mod_en = !(!cnt_own && cnt_partner);
            end else begin
                mod_en = !(cnt_own && cnt_partner);
            end
        end else if (!row[0]) begin
            use_feedback = 1'b1;  // modulator of a pair
            mod_en       = 1'b0;
        end else begin
            use_feedback = 1'b0;
            mod_en       = !cnt_own;  // cnt 1 is additive
        end
    end

    // bottom row never modulates, point it at itself
    assign mod_slot = (op >= 5'd3) ? slot - 6'd3 : slot;

endmodule

//--- src/operator_core.sv
// Stand-in FM operator
`timescale 1ns/1ps

module operator_core (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             op_start,
    input  opl_pkg::fnum_t   fnum,
    input  opl_pkg::block_t  block,
    input  logic             kon,
    input  opl_pkg::fb_t     fb,
    input  opl_pkg::tl_t     tl,
    input  logic             use_feedback,
    input  logic             mod_en,
    input  opl_pkg::op_out_t mod_value,
    input  opl_pkg::op_out_t fb_value,
    output opl_pkg::op_out_t op_out
);
    logic [16:0]      shifted;  // fnum scaled by octave
    opl_pkg::op_out_t level;
    opl_pkg::op_out_t mod_term;
    opl_pkg::op_out_t fb_term;
    opl_pkg::op_out_t level_q;
    opl_pkg::op_out_t mod_q;
    opl_pkg::op_out_t fb_q;
    logic             kon_q;
    logic             start_q;

    always_comb begin
        shifted  = {7'd0, fnum} << block;
        level    = opl_pkg::op_out_t'(shifted[16:4]) - opl_pkg::op_out_t'({tl, 3'd0});
        mod_term = mod_en ? mod_value : '0;
        fb_term  = '0;
        if (use_feedback && fb != '0) begin
            fb_term = fb_value >>> (4'd9 - fb);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_q <= 1'b0;
        end else begin
            start_q <= op_start;
        end
    end

    // terms held in cycle 5 and the wrapped sum in cycle 6
    always_ff @(posedge clk) begin
        if (op_start) begin
            level_q <= level;
            mod_q   <= mod_term;
            fb_q    <= fb_term;
            kon_q   <= kon;
        end
        if (start_q) begin
            op_out <= kon_q ? level_q + mod_q + fb_q : '0;
        end
    end

endmodule

//--- src/output_store.sv
// Per-slot operator output store
`timescale 1ns/1ps

module output_store (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  opl_pkg::slot_t   wr_slot,
    input  opl_pkg::op_out_t wr_value,
    input  opl_pkg::slot_t   mod_slot,
    output opl_pkg::op_out_t mod_value,
    input  opl_pkg::slot_t   fb_slot,
    output opl_pkg::op_out_t fb_value
);
    opl_pkg::op_out_t mem [opl_pkg::NUM_SLOTS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < opl_pkg::NUM_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en && wr_slot < opl_pkg::NUM_SLOTS) begin
            mem[wr_slot] <= wr_value;
        end
    end

    // unused slot codes read as silence
    assign mod_value = (mod_slot < opl_pkg::NUM_SLOTS) ? mem[mod_slot] : '0;
    assign fb_value  = (fb_slot < opl_pkg::NUM_SLOTS) ? mem[fb_slot] : '0;

endmodule

//--- src/opl_slot_top.sv
// FM operator scheduler top level
`timescale 1ns/1ps

module opl_slot_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               sample_en,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  opl_pkg::ram_addr_t wb_adr,
    input  opl_pkg::wb_data_t  wb_dat_w,
    output opl_pkg::wb_data_t  wb_dat_r,
    output logic               wb_ack,
    output logic               out_valid,
    output opl_pkg::slot_t     out_slot,
    output opl_pkg::op_out_t   out_value
);
    logic               fetch_req;
    opl_pkg::ram_addr_t fetch_adr;
    opl_pkg::ram_word_t fetch_dat;
    logic               ram_we;
    opl_pkg::ram_addr_t ram_adr;
    opl_pkg::ram_word_t ram_wdat;
    opl_pkg::ram_word_t ram_rdat;
    opl_pkg::slot_t     slot;        // slot in progress
    opl_pkg::conn_sel_t conn_sel;
    opl_pkg::ram_word_t owner_word;
    opl_pkg::ram_word_t partner_word;
    opl_pkg::ram_addr_t owner_adr;
    opl_pkg::tl_t       tl;
    logic               op_start;
    opl_pkg::fnum_t     fnum;
    opl_pkg::block_t    block;
    logic               kon;
    opl_pkg::fb_t       fb;
    logic               use_feedback;
    logic               mod_en;
    opl_pkg::slot_t     mod_slot;
    opl_pkg::op_out_t   mod_value;
    opl_pkg::op_out_t   fb_value;
    opl_pkg::op_out_t   op_out;

    reg_arbiter u_arbiter (
        .clk(clk), .arst_n(arst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .fetch_req(fetch_req), .fetch_adr(fetch_adr), .fetch_dat(fetch_dat),
        .ram_we(ram_we), .ram_adr(ram_adr), .ram_wdat(ram_wdat), .ram_rdat(ram_rdat)
    );

    param_ram u_ram (
        .clk(clk), .arst_n(arst_n),
        .ram_we(ram_we), .ram_adr(ram_adr), .ram_wdat(ram_wdat), .ram_rdat(ram_rdat)
    );

    slot_sequencer u_seq (
        .clk(clk), .arst_n(arst_n), .sample_en(sample_en),
        .fetch_req(fetch_req), .fetch_adr(fetch_adr), .fetch_dat(fetch_dat),
        .owner_adr(owner_adr), .slot(slot), .conn_sel(conn_sel),
        .owner_word(owner_word), .partner_word(partner_word), .tl(tl),
        .op_start(op_start), .op_out(op_out),
        .out_valid(out_valid), .out_slot(out_slot), .out_value(out_value)
    );

    slot_router u_router (
        .slot(slot), .conn_sel(conn_sel),
        .owner_word(owner_word), .partner_word(partner_word), .owner_adr(owner_adr),
        .fnum(fnum), .block(block), .kon(kon), .fb(fb),
        .use_feedback(use_feedback), .mod_en(mod_en), .mod_slot(mod_slot)
    );

    operator_core u_op (
        .clk(clk), .arst_n(arst_n), .op_start(op_start),
        .fnum(fnum), .block(block), .kon(kon), .fb(fb), .tl(tl),
        .use_feedback(use_feedback), .mod_en(mod_en),
        .mod_value(mod_value), .fb_value(fb_value), .op_out(op_out)
    );

    output_store u_store (
        .clk(clk), .arst_n(arst_n),
        .wr_en(out_valid), .wr_slot(out_slot), .wr_value(out_value),
        .mod_slot(mod_slot), .mod_value(mod_value),
        .fb_slot(slot), .fb_value(fb_value)  // own previous output
    );

endmodule

//--- bench/tb_opl_slot.sv
// FM operator scheduler testbench
`timescale 1ns/1ps

module tb_opl_slot;

    localparam int RESET_CYCLES   = 10;
    localparam int FRAME_CYCLES   = (opl_pkg::NUM_SLOTS + 4) * opl_pkg::SLOT_CYCLES;
    localparam int NUM_FRAMES     = 9;
    localparam int ACCESS_CYCLES  = 8;    // worst ack wait plus handshake
    localparam int NUM_ACCESSES   = 250;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES
                                    + NUM_ACCESSES * ACCESS_CYCLES;
    localparam int MAX_ACK_WAIT   = 6;
    localparam int SPARE_ADR      = 100;  // between the level words and the select
    localparam int NUM_CH         = opl_pkg::NUM_BANKS * opl_pkg::NUM_CH_PER_BANK;

    logic               clk;
    logic               arst_n;
    logic               sample_en;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    opl_pkg::ram_addr_t wb_adr;
    opl_pkg::wb_data_t  wb_dat_w;
    opl_pkg::wb_data_t  wb_dat_r;
    logic               wb_ack;
    logic               out_valid;
    opl_pkg::slot_t     out_slot;
    opl_pkg::op_out_t   out_value;

    int                 cycle_cnt = 0;
    logic [31:0]        lfsr_state;
    opl_pkg::ram_word_t ch_word [NUM_CH];             // model copy of the channel words
    opl_pkg::tl_t       tl_val [opl_pkg::NUM_SLOTS];
    opl_pkg::conn_sel_t conn_val;
    int                 model_out [opl_pkg::NUM_SLOTS];

    opl_slot_top dut (
        .clk(clk), .arst_n(arst_n), .sample_en(sample_en),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .out_valid(out_valid), .out_slot(out_slot), .out_value(out_value)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_run("simulation ran out of cycles before the tests finished");
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic value_error(input string test, input int expected, input int actual);
        stop_run($sformatf("[ERROR] %s expected %0d actual %0d", test, expected, actual));
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // predicts one slot and keeps its result for later modulation and feedback
    function automatic int model_slot(input int s);
        int                 bank;
        int                 op;
        int                 col;
        int                 row;
        int                 chan;
        int                 fb;
        int                 sum;
        logic               four_op;
        logic               cnt_own;
        logic               cnt_partner;
        logic               use_fb;
        logic               mod_on;
        opl_pkg::ram_word_t own;
        opl_pkg::op_out_t   wrapped;
        bank        = s / opl_pkg::NUM_OPS_PER_BANK;
        op          = s % opl_pkg::NUM_OPS_PER_BANK;
        col         = op % 3;
        row         = op / 3;
        four_op     = (row == 2 || row == 3) && conn_val[3 * bank + col];
        chan        = opl_pkg::NUM_CH_PER_BANK * bank + col + (four_op ? 0 : 3 * (row / 2));
        own         = ch_word[chan];
        cnt_own     = own[16];
        cnt_partner = ch_word[opl_pkg::NUM_CH_PER_BANK * bank + col + 3][16];
        fb          = int'(own[15:13]);
        if (four_op) begin
            use_fb = 1'b0;
            mod_on = (row == 2) ? !(!cnt_own && cnt_partner) : !(cnt_own && cnt_partner);
        end else begin
            use_fb = (row % 2 == 0);
            mod_on = (row % 2 == 1) && !cnt_own;
        end
        sum = 0;
        if (own[17]) begin
            sum = ((int'(own[9:0]) << own[12:10]) >> 4) - 8 * int'(tl_val[s]);
            if (mod_on) begin
                sum += model_out[s - 3];
            end
            if (use_fb && fb != 0) begin
                sum += model_out[s] >>> (9 - fb);  // still last frame's value here
            end
        end
        wrapped      = sum[12:0];
        model_out[s] = int'(wrapped);
        return model_out[s];
    endfunction

    task automatic wb_access(input logic we, input opl_pkg::ram_addr_t adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int wait_cyc;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        wait_cyc = 0;
        do begin
            @(negedge clk);
            wait_cyc++;
        end while (!wb_ack);
        rdat = wb_dat_r;
        assert (wait_cyc <= MAX_ACK_WAIT)
            else stop_run($sformatf("wb_ack came %0d cycles after the request", wait_cyc));
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        assert (!wb_ack) else stop_run("wb_ack stayed high for more than one cycle");
    endtask

    task automatic wb_write(input opl_pkg::ram_addr_t adr, input logic [31:0] data);
        logic [31:0] ignored;
        wb_access(1'b1, adr, data, ignored);
    endtask

    task automatic wb_read(input opl_pkg::ram_addr_t adr, output logic [31:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic set_channel(input int idx, input logic kon, input logic cnt,
                               input opl_pkg::fb_t fb);
        ch_word[idx] = {kon, cnt, fb, 3'(take_bits(3)), 10'(take_bits(10))};
        wb_write(opl_pkg::CH_BASE + 7'(idx), 32'(ch_word[idx]));
    endtask

    task automatic set_tl(input int s, input opl_pkg::tl_t lvl);
        tl_val[s] = lvl;
        wb_write(opl_pkg::TL_BASE + 7'(s), 32'(lvl));
    endtask

    task automatic set_conn(input opl_pkg::conn_sel_t sel);
        conn_val = sel;
        wb_write(opl_pkg::CONN_ADDR, 32'(sel));
    endtask

    // one frame with every strobe checked for edge, slot and value
    task automatic run_frame(input string test);
        int edge_cyc;
        int k;
        int expected;
        @(negedge clk);
        edge_cyc = cycle_cnt + 2;  // dut sees sample_en on the second rising edge
        @(posedge clk);
        sample_en <= 1'b1;
        @(posedge clk);
        sample_en <= 1'b0;
        k = 0;
        while (k < opl_pkg::NUM_SLOTS) begin
            @(negedge clk);
            if (out_valid) begin
                expected = model_slot(k);
                assert (cycle_cnt + 1 == edge_cyc + opl_pkg::SLOT_CYCLES * (k + 1))
                    else value_error({test, " strobe cycle"},
                                     edge_cyc + opl_pkg::SLOT_CYCLES * (k + 1), cycle_cnt + 1);
                assert (int'(out_slot) == k)
                    else value_error({test, " slot order"}, k, int'(out_slot));
                assert (int'(out_value) == expected)
                    else value_error($sformatf("%s slot %0d", test, k), expected,
                                     int'(out_value));
                k++;
            end
        end
        repeat (2 * opl_pkg::SLOT_CYCLES) begin
            @(negedge clk);
            assert (!out_valid) else stop_run({test, " gave a strobe after slot 35"});
        end
    endtask

    initial begin
        logic [31:0] rdat;
        clk        = 1'b0;
        arst_n     = 1'b0;
        sample_en  = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lfsr_state = 32'h834b;
        conn_val   = '0;
        for (int i = 0; i < opl_pkg::NUM_SLOTS; i++) begin
            model_out[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // reset state and register read-back
        @(negedge clk);
        assert (!out_valid && !wb_ack) else stop_run("out_valid or wb_ack high after reset");
        wb_read(opl_pkg::CONN_ADDR, rdat);
        assert (rdat == 0) else value_error("reset_readback", 0, int'(rdat));
        for (int i = 0; i < NUM_CH; i++) begin
            set_channel(i, 1'(take_bits(1)), 1'(take_bits(1)), 3'(take_bits(3)));
        end
        for (int s = 0; s < opl_pkg::NUM_SLOTS; s++) begin
            set_tl(s, 6'(take_bits(6)));
        end
        set_conn(6'(take_bits(6)));
        for (int i = 0; i < NUM_CH; i++) begin
            wb_read(opl_pkg::CH_BASE + 7'(i), rdat);
            assert (rdat == 32'(ch_word[i]))
                else value_error("channel_readback", int'(ch_word[i]), int'(rdat));
        end
        for (int s = 0; s < opl_pkg::NUM_SLOTS; s++) begin
            wb_read(opl_pkg::TL_BASE + 7'(s), rdat);
            assert (rdat == 32'(tl_val[s]))
                else value_error("level_readback", int'(tl_val[s]), int'(rdat));
        end
        wb_read(opl_pkg::CONN_ADDR, rdat);
        assert (rdat == 32'(conn_val)) else value_error("select_readback", conn_val, rdat);

        // frame timing with a second sample_en in the middle of the frame
        fork
            run_frame("frame_timing");
            begin
                repeat (100) @(posedge clk);
                sample_en <= 1'b1;
                @(posedge clk);
                sample_en <= 1'b0;
            end
        join

        // two-operator FM and additive
        set_conn('0);
        for (int i = 0; i < NUM_CH; i++) begin
            set_channel(i, 1'b1, 1'(take_bits(1)), 3'(take_bits(3)));
        end
        run_frame("two_op");

        // four-operator voices with one cnt pair per frame
        set_conn('1);
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (i % opl_pkg::NUM_CH_PER_BANK < 3) begin
                    set_channel(i, 1'b1, 1'(f % 2), 3'(take_bits(3)));
                end else if (i % opl_pkg::NUM_CH_PER_BANK < 6) begin
                    set_channel(i, 1'b1, 1'(f / 2), 3'(take_bits(3)));
                end else begin
                    set_channel(i, 1'b1, 1'(take_bits(1)), 3'(take_bits(3)));
                end
            end
            run_frame($sformatf("four_op_cnt%0d", f));
        end

        // feedback over two frames with channel 4 of each bank keyed off
        set_conn('0);
        for (int i = 0; i < NUM_CH; i++) begin
            set_channel(i, i % opl_pkg::NUM_CH_PER_BANK != 4, 1'(take_bits(1)),
                        3'(1 + take_bits(3) % 7));
        end
        run_frame("feedback_first");
        run_frame("feedback_second");

        // host traffic while a frame runs
        fork
            run_frame("host_during_frame");
            begin : host_traffic
                logic [31:0] wdat;
                logic [31:0] back;
                logic [31:0] kept;
                repeat (20) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    wdat = take_bits(32);
                    kept = wdat & 32'h3ffff;  // only the low 18 bits are stored
                    wb_write(7'(SPARE_ADR + i), wdat);
                    wb_read(7'(SPARE_ADR + i), back);
                    assert (back == kept)
                        else value_error("host_during_frame readback", int'(kept), int'(back));
                    repeat (i) @(posedge clk);  // walks the request across slot phases
                end
            end
        join

        $display("all tests passed");
        $finish;
    end

endmodule

//--- opl_slot_top.f
src/opl_pkg.sv
src/param_ram.sv
src/reg_arbiter.sv
src/slot_sequencer.sv
src/slot_router.sv
src/operator_core.sv
src/output_store.sv
src/opl_slot_top.sv
bench/tb_opl_slot.sv

//--- Makefile
# Verilator build for the FM operator scheduler testbench

TOP := tb_opl_slot

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): opl_slot_top.f src/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f opl_slot_top.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
